// ==== rtl/fpslice_pkg.sv ====
/*
 * Non-computational FP slice definitions
 * Datapath size, source formats, operation encodings, status flags and
 * the helpers that map formats and lane indices to bit widths.
 */
`default_nettype none

package fpslice_pkg;

  localparam int unsigned WIDTH        = 32;
  localparam int unsigned NUM_LANES    = 4;  // One lane per FP8 field
  localparam int unsigned NUM_OPERANDS = 2;
  localparam int unsigned NUM_FORMATS  = 3;

  typedef enum logic [1:0] {
    FP32 = 2'd0,
    FP16 = 2'd1,
    FP8  = 2'd2
  } fp_format_e;

  typedef enum logic {
    MINMAX = 1'b0,
    SGNJ   = 1'b1
  } operation_e;

  // Rounding mode field, selects the operation variant
  typedef enum logic [2:0] {
    RNE = 3'b000,  // min / sgnj
    RTZ = 3'b001,  // max / sgnjn
    RDN = 3'b010,  // sgnjx
    RUP = 3'b011,
    RMM = 3'b100,
    DYN = 3'b111
  } roundmode_e;

  typedef struct packed {
    logic NV;
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  // Travels with lane 0 down to the result packer
  typedef struct packed {
    fp_format_e fmt;
    logic       vectorial;
  } aux_t;

  typedef logic [3:0] fmt_logic_t;  // One bit per format encoding

  function automatic int unsigned fp_width(fp_format_e fmt);
    case (fmt)
      FP16:    return 16;
      FP8:     return 8;
      default: return 32;
    endcase
  endfunction

  function automatic int unsigned man_bits(fp_format_e fmt);
    case (fmt)
      FP16:    return 10;
      FP8:     return 2;   // E5M2
      default: return 23;
    endcase
  endfunction

  // Formats whose field at this lane index still fits into the datapath
  function automatic fmt_logic_t lane_formats(int unsigned lane);
    fmt_logic_t res;
    res = '0;
    for (int unsigned f = 0; f < NUM_FORMATS; f++) begin
      res[f] = ((lane + 1) * fp_width(fp_format_e'(f))) <= WIDTH;
    end
    return res;
  endfunction

  // Widest format a lane has to hold
  function automatic int unsigned lane_width(int unsigned lane);
    fmt_logic_t  fmts;
    int unsigned res;
    fmts = lane_formats(lane);
    res  = 0;
    for (int unsigned f = 0; f < NUM_FORMATS; f++) begin
      if (fmts[f] && (fp_width(fp_format_e'(f)) > res)) begin
        res = fp_width(fp_format_e'(f));
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// ==== rtl/fpslice_pipe.sv ====
/*
 * Valid/ready stall pipeline
 * NumPipeRegs enable-register stages for an arbitrary payload type, with
 * bubble popping and a synchronous flush of all valid bits.
 */
`default_nettype none

module fpslice_pipe #(
  parameter int unsigned NumPipeRegs = 0,
  parameter type         payload_t   = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t data_o,
  output logic     busy_o
);

  // Index i holds the item after i register stages
  payload_t             data_q [0:NumPipeRegs];
  logic [0:NumPipeRegs] valid_q;
  logic [0:NumPipeRegs] ready;

  assign data_q[0]  = data_i;
  assign valid_q[0] = in_valid_i;

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    logic reg_ena;

    // Advance if the next stage takes the item or only holds a bubble
    assign ready[i] = ready[i+1] | ~valid_q[i+1];
    assign reg_ena  = ready[i] & valid_q[i];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        valid_q[i+1] <= 1'b0;       // Drop everything in flight
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (reg_ena) begin
        data_q[i+1] <= data_q[i];
      end
    end
  end

  assign ready[NumPipeRegs] = out_ready_i;  // Downstream drives the last stage
  assign in_ready_o         = ready[0];
  assign out_valid_o        = valid_q[NumPipeRegs];
  assign data_o             = data_q[NumPipeRegs];

  // Busy while any register stage holds an item
  always_comb begin : busy_flag
    busy_o = 1'b0;
    for (int unsigned i = 1; i <= NumPipeRegs; i++) begin
      busy_o = busy_o | valid_q[i];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fpslice_noncomp_lane.sv ====
/*
 * Non-computational SIMD lane
 * Slices its field out of the operand bus, runs min/max or sign injection
 * for the formats that fit this lane and pipes the result downstream.
 */
`default_nettype none

module fpslice_noncomp_lane #(
  parameter int unsigned Lane        = 0,
  parameter int unsigned NumPipeRegs = 0,
  parameter type         TagType     = logic
) (
  input  logic                                                         clk_i,
  input  logic                                                         rst_n_i,
  input  logic                                                         flush_i,
  input  logic [fpslice_pkg::NUM_OPERANDS-1:0][fpslice_pkg::WIDTH-1:0] operands_i,
  input  fpslice_pkg::operation_e                                      op_i,
  input  fpslice_pkg::roundmode_e                                      rnd_mode_i,
  input  fpslice_pkg::fp_format_e                                      src_fmt_i,
  input  logic                                                         vectorial_op_i,
  input  TagType                                                       tag_i,
  input  logic                                                         mask_i,
  input  logic                                                         in_valid_i,
  output logic                                                         in_ready_o,
  output logic                                                         out_valid_o,
  input  logic                                                         out_ready_i,
  output logic [fpslice_pkg::WIDTH-1:0]                                result_o,
  output fpslice_pkg::status_t                                         status_o,
  output TagType                                                       tag_o,
  output fpslice_pkg::aux_t                                            aux_o,
  output logic                                                         mask_o,
  output logic                                                         busy_o
);

  import fpslice_pkg::*;

  localparam int unsigned LANE_WIDTH = lane_width(Lane);

  typedef struct packed {
    logic [LANE_WIDTH-1:0] result;
    status_t               status;
    TagType                tag;
    aux_t                  aux;
    logic                  mask;
  } lane_payload_t;

  logic [NUM_OPERANDS-1:0][LANE_WIDTH-1:0] local_operands;
  logic [LANE_WIDTH-1:0]   sign_bit, mag_mask, man_mask, exp_mask, quiet_bit, qnan;
  logic [WIDTH-1:0]        box_mask;
  logic [NUM_OPERANDS-1:0] op_sign, op_nan, op_snan;
  logic [LANE_WIDTH-1:0]   mag_a, mag_b, op_result;
  logic                    a_lt_b, inj_sign;
  status_t                 op_status;
  lane_payload_t           pipe_in, pipe_out;

  // --------------------------------------------------------------------------
  // Format fields of the current source format
  // --------------------------------------------------------------------------
  assign sign_bit  = LANE_WIDTH'(64'd1 << (fp_width(src_fmt_i) - 1));
  assign mag_mask  = LANE_WIDTH'((64'd1 << (fp_width(src_fmt_i) - 1)) - 64'd1);
  assign man_mask  = LANE_WIDTH'((64'd1 << man_bits(src_fmt_i)) - 64'd1);
  assign exp_mask  = mag_mask & ~man_mask;
  assign quiet_bit = LANE_WIDTH'(64'd1 << (man_bits(src_fmt_i) - 1));
  assign qnan      = exp_mask | quiet_bit;  // Canonical NaN
  assign box_mask  = ~WIDTH'((64'd1 << fp_width(src_fmt_i)) - 64'd1);

  always_comb begin : prepare_operands
    for (int unsigned i = 0; i < NUM_OPERANDS; i++) begin
      local_operands[i] = LANE_WIDTH'(operands_i[i] >> (Lane * fp_width(src_fmt_i)));
      // Scalars narrower than the bus must be NaN-boxed
      if ((Lane == 0) && !vectorial_op_i && ((operands_i[i] & box_mask) != box_mask)) begin
        local_operands[i] = qnan;
      end
    end
  end

  always_comb begin : classify
    for (int unsigned i = 0; i < NUM_OPERANDS; i++) begin
      op_sign[i] = |(local_operands[i] & sign_bit);
      op_nan[i]  = ((local_operands[i] & exp_mask) == exp_mask) &&
                   |(local_operands[i] & man_mask);
      op_snan[i] = op_nan[i] && !(|(local_operands[i] & quiet_bit));
    end
  end

  assign mag_a = local_operands[0] & mag_mask;
  assign mag_b = local_operands[1] & mag_mask;

  // Sign-magnitude compare, so -0 sorts below +0
  always_comb begin : compare
    if (op_sign[0] != op_sign[1]) begin
      a_lt_b = op_sign[0];
    end else if (op_sign[0]) begin
      a_lt_b = mag_a > mag_b;
    end else begin
      a_lt_b = mag_a < mag_b;
    end
  end

  always_comb begin : injected_sign
    case (rnd_mode_i)
      RTZ:     inj_sign = ~op_sign[1];            // sgnjn
      RDN:     inj_sign = op_sign[0] ^ op_sign[1]; // sgnjx
      default: inj_sign = op_sign[1];
    endcase
  end

  // --------------------------------------------------------------------------
  // Operation
  // --------------------------------------------------------------------------
  always_comb begin : operation
    op_status = '0;
    if (op_i == MINMAX) begin
      op_status.NV = |op_snan;
      if (&op_nan) begin
        op_result = qnan;
      end else if (op_nan[0]) begin
        op_result = local_operands[1];
      end else if (op_nan[1]) begin
        op_result = local_operands[0];
      end else if (rnd_mode_i == RTZ) begin
        op_result = a_lt_b ? local_operands[1] : local_operands[0]; // max
      end else begin
        op_result = a_lt_b ? local_operands[0] : local_operands[1]; // min
      end
    end else begin
      op_result = mag_a | (inj_sign ? sign_bit : '0);
    end
  end

  assign pipe_in = '{
    result: op_result,
    status: op_status,
    tag:    tag_i,
    aux:    '{fmt: src_fmt_i, vectorial: vectorial_op_i},
    mask:   mask_i
  };

  fpslice_pipe #(
    .NumPipeRegs ( NumPipeRegs    ),
    .payload_t   ( lane_payload_t )
  ) i_pipe (
    .clk_i,
    .rst_n_i,
    .flush_i,
    .in_valid_i,
    .in_ready_o,
    .data_i      ( pipe_in  ),
    .out_valid_o,
    .out_ready_i,
    .data_o      ( pipe_out ),
    .busy_o
  );

  always_comb begin : unpack_result
    result_o                 = '1;  // Bits above the lane stay NaN-boxed
    result_o[LANE_WIDTH-1:0] = pipe_out.result;
  end

  assign status_o = pipe_out.status;
  assign tag_o    = pipe_out.tag;
  assign aux_o    = pipe_out.aux;
  assign mask_o   = pipe_out.mask;

endmodule

`default_nettype wire

// ==== rtl/fpslice_result_pack.sv ====
/*
 * SIMD result packer
 * Places each lane's field into the output word for the result format,
 * NaN-boxes unused bits and collapses lane flags through the SIMD mask.
 */
`default_nettype none

module fpslice_result_pack (
  input  logic [fpslice_pkg::NUM_LANES-1:0][fpslice_pkg::WIDTH-1:0] lane_result_i,
  input  fpslice_pkg::status_t [fpslice_pkg::NUM_LANES-1:0]         lane_status_i,
  input  logic [fpslice_pkg::NUM_LANES-1:0]                         lane_valid_i,
  input  logic [fpslice_pkg::NUM_LANES-1:0]                         lane_mask_i,
  input  fpslice_pkg::aux_t                                         aux_i,
  output logic [fpslice_pkg::WIDTH-1:0]                             result_o,
  output fpslice_pkg::status_t                                      status_o
);

  import fpslice_pkg::*;

  logic [NUM_FORMATS-1:0][WIDTH-1:0] fmt_result;  // Packed word per format
  logic [NUM_LANES-1:0]              lane_used;

  // --------------------------------------------------------------------------
  // Lane selection
  // --------------------------------------------------------------------------
  for (genvar lane = 0; lane < NUM_LANES; lane++) begin : gen_lane_used
    // Upper lanes only contribute to vectorial results
    assign lane_used[lane] = lane_valid_i[lane] & ((lane == 0) | aux_i.vectorial);
  end

  // --------------------------------------------------------------------------
  // Per-format packing
  // --------------------------------------------------------------------------
  for (genvar fmt = 0; fmt < NUM_FORMATS; fmt++) begin : gen_fmt
    localparam int unsigned FW        = fp_width(fp_format_e'(fmt));
    localparam int unsigned FMT_LANES = WIDTH / FW;

    for (genvar lane = 0; lane < FMT_LANES; lane++) begin : gen_field
      // Idle lanes read as all ones
      assign fmt_result[fmt][lane*FW +: FW] =
          lane_used[lane] ? lane_result_i[lane][FW-1:0] : {FW{1'b1}};
    end
  end

  always_comb begin : select_format
    result_o = '1;
    if (aux_i.fmt < NUM_FORMATS) begin
      result_o = fmt_result[aux_i.fmt];
    end
  end

  // --------------------------------------------------------------------------
  // Status collapse
  // --------------------------------------------------------------------------
  always_comb begin : collapse_status
    status_o = '0;
    for (int unsigned l = 0; l < NUM_LANES; l++) begin
      // Masked-off lanes keep their flags to themselves
      if (lane_used[l] && lane_mask_i[l]) begin
        status_o = status_o | lane_status_i[l];
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fpslice_noncomp_multifmt.sv ====
/*
 * Multi-format non-computational FP slice
 * Min/max and sign injection on FP32, FP16 and FP8, scalar on lane 0 or
 * vectorial across every lane that fits the format.
 */
`default_nettype none

module fpslice_noncomp_multifmt #(
  parameter int unsigned NumPipeRegs = 0,
  parameter type         TagType     = logic
) (
  input  logic                                                         clk_i,
  input  logic                                                         rst_n_i,
  input  logic                                                         flush_i,
  input  logic [fpslice_pkg::NUM_OPERANDS-1:0][fpslice_pkg::WIDTH-1:0] operands_i,
  input  fpslice_pkg::operation_e                                      op_i,
  input  fpslice_pkg::roundmode_e                                      rnd_mode_i,
  input  fpslice_pkg::fp_format_e                                      src_fmt_i,
  input  logic                                                         vectorial_op_i,
  input  TagType                                                       tag_i,
  input  logic [fpslice_pkg::NUM_LANES-1:0]                            simd_mask_i,
  input  logic                                                         in_valid_i,
  output logic                                                         in_ready_o,
  output logic [fpslice_pkg::WIDTH-1:0]                                result_o,
  output fpslice_pkg::status_t                                         status_o,
  output TagType                                                       tag_o,
  output logic                                                         out_valid_o,
  input  logic                                                         out_ready_i,
  output logic                                                         busy_o
);

  import fpslice_pkg::*;

  logic    [NUM_LANES-1:0]            lane_in_valid, lane_in_ready, lane_out_valid;
  logic    [NUM_LANES-1:0]            lane_masks, lane_busy;
  logic    [NUM_LANES-1:0][WIDTH-1:0] lane_results;
  status_t [NUM_LANES-1:0]            lane_status;
  TagType  [NUM_LANES-1:0]            lane_tags;   // Only lane 0 is read
  aux_t    [NUM_LANES-1:0]            lane_aux;    // Same here

  // --------------------------------------------------------------------------
  // Lanes
  // --------------------------------------------------------------------------
  for (genvar lane = 0; lane < NUM_LANES; lane++) begin : gen_lanes
    localparam fmt_logic_t LANE_FORMATS = lane_formats(lane);
    logic lane_mask;

    if (lane == 0) begin : gen_scalar_lane
      assign lane_in_valid[lane] = in_valid_i;
      assign lane_mask           = simd_mask_i[lane] | ~vectorial_op_i; // Scalars never masked
    end else begin : gen_vector_lane
      // Accept only together with lane 0 so all pipes stay in lockstep
      assign lane_in_valid[lane] = in_valid_i & vectorial_op_i & lane_in_ready[0] &
                                   LANE_FORMATS[src_fmt_i];
      assign lane_mask           = simd_mask_i[lane];
    end

    fpslice_noncomp_lane #(
      .Lane        ( lane        ),
      .NumPipeRegs ( NumPipeRegs ),
      .TagType     ( TagType     )
    ) i_lane (
      .clk_i,
      .rst_n_i,
      .flush_i,
      .operands_i,
      .op_i,
      .rnd_mode_i,
      .src_fmt_i,
      .vectorial_op_i,
      .tag_i,
      .mask_i      ( lane_mask            ),
      .in_valid_i  ( lane_in_valid[lane]  ),
      .in_ready_o  ( lane_in_ready[lane]  ),
      .out_valid_o ( lane_out_valid[lane] ),
      .out_ready_i,
      .result_o    ( lane_results[lane]   ),
      .status_o    ( lane_status[lane]    ),
      .tag_o       ( lane_tags[lane]      ),
      .aux_o       ( lane_aux[lane]       ),
      .mask_o      ( lane_masks[lane]     ),
      .busy_o      ( lane_busy[lane]      )
    );
  end

  // --------------------------------------------------------------------------
  // Output side
  // --------------------------------------------------------------------------
  fpslice_result_pack i_result_pack (
    .lane_result_i ( lane_results   ),
    .lane_status_i ( lane_status    ),
    .lane_valid_i  ( lane_out_valid ),
    .lane_mask_i   ( lane_masks     ),
    .aux_i         ( lane_aux[0]    ),
    .result_o,
    .status_o
  );

  assign in_ready_o  = lane_in_ready[0];   // Lane 0 paces the slice
  assign out_valid_o = lane_out_valid[0];
  assign tag_o       = lane_tags[0];
  assign busy_o      = |lane_busy;

endmodule

`default_nettype wire

// ==== tests/tb_fpslice_noncomp_multifmt.sv ====
/*
 * Testbench for the multi-format non-computational FP slice
 * Random min/max and sign injection traffic with special values, checked
 * against a reference model under back-pressure, flushes and fixed latency.
 */
`default_nettype none

module tb_fpslice_noncomp_multifmt;

  timeunit 1ns;
  timeprecision 100ps;

  import fpslice_pkg::*;

  localparam int unsigned NUM_PIPE   = 2;
  localparam int unsigned NUM_TXN    = 400;
  localparam int unsigned MAX_CYCLES = 8 * NUM_TXN + 100;

  logic                                clk = 1'b0;
  logic                                rst_n, flush, vec, in_valid, in_ready;
  logic                                out_valid, out_ready, busy;
  logic [NUM_OPERANDS-1:0][WIDTH-1:0] operands;
  operation_e                          op;
  roundmode_e                          rnd;
  fp_format_e                          fmt;
  logic [7:0]                          tag, tag_out;
  logic [NUM_LANES-1:0]                simd_mask;
  logic [WIDTH-1:0]                    result;
  status_t                             status;

  // Scoreboard, one entry per accepted operation
  logic [WIDTH-1:0] exp_result [$];
  status_t          exp_status [$];
  logic [7:0]       exp_tag    [$];
  int unsigned      exp_cycle  [$];

  int          seed = 32'h5d96;
  int unsigned cycles = 0;
  int unsigned txn = 0;
  int unsigned err_count = 0;
  logic        hold_ready, check_latency;

  always #20 clk = ~clk;

  fpslice_noncomp_multifmt #(
    .NumPipeRegs ( NUM_PIPE    ),
    .TagType     ( logic [7:0] )
  ) fpslice_noncomp_multifmt_i (
    .clk_i          ( clk       ),
    .rst_n_i        ( rst_n     ),
    .flush_i        ( flush     ),
    .operands_i     ( operands  ),
    .op_i           ( op        ),
    .rnd_mode_i     ( rnd       ),
    .src_fmt_i      ( fmt       ),
    .vectorial_op_i ( vec       ),
    .tag_i          ( tag       ),
    .simd_mask_i    ( simd_mask ),
    .in_valid_i     ( in_valid  ),
    .in_ready_o     ( in_ready  ),
    .result_o       ( result    ),
    .status_o       ( status    ),
    .tag_o          ( tag_out   ),
    .out_valid_o    ( out_valid ),
    .out_ready_i    ( out_ready ),
    .busy_o         ( busy      )
  );

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic int unsigned rand_below(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic int unsigned mant_len(fp_format_e f);
    case (f)
      FP16:    return 10;
      FP8:     return 2;   // E5M2
      default: return 23;
    endcase
  endfunction

  function automatic logic [31:0] low_ones(int unsigned w);
    return 32'((64'd1 << w) - 64'd1);
  endfunction

  function automatic logic [31:0] canon_nan(fp_format_e f);
    case (f)
      FP16:    return 32'h0000_7e00;
      FP8:     return 32'h0000_007e;
      default: return 32'h7fc0_0000;
    endcase
  endfunction

  function automatic logic [31:0] place_field(logic [31:0] word, logic [31:0] field,
                                              int unsigned l, int unsigned w);
    return (word & ~(low_ones(w) << (l * w))) | ((field & low_ones(w)) << (l * w));
  endfunction

  // Mostly special encodings, so NaN and zero corners come up often
  function automatic logic [31:0] rand_field(fp_format_e f);
    int unsigned w, mb;
    logic [31:0] exp_m, man, qbit, sgn;
    w     = fp_width(f);
    mb    = mant_len(f);
    exp_m = low_ones(w - 1) & ~low_ones(mb);
    qbit  = 32'd1 << (mb - 1);
    man   = $random(seed) & low_ones(mb);
    sgn   = rand_below(2) << (w - 1);
    case (rand_below(8))
      0:       return 32'd0;
      1:       return 32'd1 << (w - 1);               // -0
      2:       return sgn | exp_m;                    // Infinity
      3:       return sgn | exp_m | qbit | man;       // Quiet NaN
      4:       return sgn | exp_m | (man & ~qbit) | 32'd1;
      default: return $random(seed) & low_ones(w);
    endcase
  endfunction

  function automatic logic [31:0] make_operand(fp_format_e f, logic v);
    int unsigned w;
    logic [31:0] word;
    w    = fp_width(f);
    word = '1;
    if (v) begin
      for (int unsigned l = 0; l < 32 / w; l++) begin
        word = place_field(word, rand_field(f), l, w);
      end
    end else begin
      word = place_field(word, rand_field(f), 0, w);
      if (w < 32 && rand_below(8) == 0) begin
        word = (word & low_ones(w)) | ($random(seed) & ~low_ones(w)); // Bad boxing
      end
    end
    return word;
  endfunction

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  task automatic field_op(input logic [31:0] x, input logic [31:0] y, input fp_format_e f,
                          input operation_e o, input roundmode_e m,
                          output logic [31:0] r, output logic nv);
    int unsigned w, mb;
    logic [31:0] exp_m, man_m, qbit, sbit;
    logic        xs, ys, xn, yn, new_sign;
    longint      xo, yo;
    w     = fp_width(f);
    mb    = mant_len(f);
    sbit  = 32'd1 << (w - 1);
    man_m = low_ones(mb);
    exp_m = low_ones(w - 1) & ~man_m;
    qbit  = 32'd1 << (mb - 1);
    xs    = (x & sbit) != 0;
    ys    = (y & sbit) != 0;
    xn    = ((x & exp_m) == exp_m) && ((x & man_m) != 0);
    yn    = ((y & exp_m) == exp_m) && ((y & man_m) != 0);
    // Total order key, -0 lands just below +0
    xo    = xs ? -longint'(x & low_ones(w - 1)) - 1 : longint'(x & low_ones(w - 1));
    yo    = ys ? -longint'(y & low_ones(w - 1)) - 1 : longint'(y & low_ones(w - 1));
    nv    = 1'b0;
    if (o == SGNJ) begin
      if (m == RTZ) new_sign = !ys;
      else if (m == RDN) new_sign = xs ^ ys;
      else new_sign = ys;
      r = (x & ~sbit) | (new_sign ? sbit : 32'd0);
    end else begin
      nv = (xn && (x & qbit) == 0) || (yn && (y & qbit) == 0);
      if (xn && yn) r = canon_nan(f);
      else if (xn) r = y;
      else if (yn) r = x;
      else if (m == RTZ) r = (xo < yo) ? y : x;  // max
      else r = (xo < yo) ? x : y;
    end
  endtask

  task automatic predict(output logic [31:0] res, output status_t stat);
    int unsigned w, lanes;
    logic [31:0] fa, fb, fr;
    logic        nv;
    w     = fp_width(fmt);
    lanes = vec ? 32 / w : 1;
    res   = '1;
    stat  = '0;
    for (int unsigned l = 0; l < lanes; l++) begin
      fa = (operands[0] >> (l * w)) & low_ones(w);
      fb = (operands[1] >> (l * w)) & low_ones(w);
      if (!vec && w < 32) begin
        if ((operands[0] | low_ones(w)) != 32'hffff_ffff) fa = canon_nan(fmt);
        if ((operands[1] | low_ones(w)) != 32'hffff_ffff) fb = canon_nan(fmt);
      end
      field_op(fa, fb, fmt, op, rnd, fr, nv);
      res = place_field(res, fr, l, w);
      if (nv && (simd_mask[l] || !vec)) stat.NV = 1'b1;
    end
  endtask

  // --------------------------------------------------------------------------
  // Checking
  // --------------------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("Mismatch at %0t ns: %s got %h, expected %h", $time, name, got, exp);
      $display("Done: errors found");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string reason);
    err_count++;
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1);
  endtask

  always @(posedge clk) begin : watchdog
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) abort_run("Timeout: the run did not finish in time");
  end

  // Sampled mid-cycle, handshakes complete at the following rising edge
  always @(negedge clk) begin : scoreboard
    logic [31:0] res;
    status_t     stat;
    if (rst_n) begin
      if (busy && exp_result.size() == 0) abort_run("busy_o is high with nothing in flight");
      if (flush) begin
        exp_result.delete();
        exp_status.delete();
        exp_tag.delete();
        exp_cycle.delete();
      end else begin
        if (out_valid && out_ready) begin
          if (exp_result.size() == 0) begin
            abort_run("Output handshake without a pending operation");
          end else begin
            check_value("result_o", result, exp_result.pop_front());
            check_value("status_o", 32'(status), 32'(exp_status.pop_front()));
            check_value("tag_o", 32'(tag_out), 32'(exp_tag.pop_front()));
            if (check_latency) check_value("latency", cycles - exp_cycle[0], NUM_PIPE);
            void'(exp_cycle.pop_front());
          end
        end
        if (in_valid && in_ready) begin
          predict(res, stat);
          exp_result.push_back(res);
          exp_status.push_back(stat);
          exp_tag.push_back(tag);
          exp_cycle.push_back(cycles);
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  task automatic next_cycle();
    @(posedge clk);
    #2;
    flush     = 1'b0;
    out_ready = hold_ready || (rand_below(10) >= 3);  // Low about 30%
  endtask

  task automatic send_op(input int unsigned phase);
    logic accepted;
    if (rand_below(8) == 0) begin
      in_valid = 1'b0;
      next_cycle();
    end
    case (phase)
      0: begin
        fmt = fp_format_e'(2'(rand_below(3)));
        vec = rand_below(2);
      end
      1: begin  // Lane 0 only
        fmt = fp_format_e'(2'(rand_below(3)));
        vec = (fmt == FP32) ? rand_below(2) : 1'b0;
      end
      2: begin
        fmt = FP16;
        vec = 1'b1;
      end
      default: begin
        fmt = FP8;
        vec = 1'b1;
      end
    endcase
    op          = operation_e'(rand_below(2));
    rnd         = roundmode_e'(3'(rand_below(op == SGNJ ? 3 : 2)));
    operands[0] = make_operand(fmt, vec);
    operands[1] = make_operand(fmt, vec);
    simd_mask   = 4'(rand_below(16));
    tag         = 8'(txn);
    in_valid    = 1'b1;
    accepted    = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = in_ready;
      next_cycle();
    end
    txn++;
  endtask

  task automatic flush_pipe();
    in_valid  = 1'b0;
    out_ready = 1'b0;
    flush     = 1'b1;
    next_cycle();
  endtask

  task automatic run_phase(input int unsigned phase, input int unsigned count);
    for (int unsigned i = 0; i < count; i++) begin
      if (phase != 0 && i == count / 2) flush_pipe();
      send_op(phase);
    end
    in_valid = 1'b0;
  endtask

  task automatic drain();
    hold_ready = 1'b1;
    out_ready  = 1'b1;
    in_valid   = 1'b0;
    while (exp_result.size() != 0) next_cycle();
  endtask

  initial begin : stimulus
    rst_n         = 1'b0;
    flush         = 1'b0;
    operands      = '0;
    op            = MINMAX;
    rnd           = RNE;
    fmt           = FP32;
    vec           = 1'b0;
    tag           = '0;
    simd_mask     = '0;
    in_valid      = 1'b0;
    out_ready     = 1'b1;
    hold_ready    = 1'b1;
    check_latency = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;

    check_latency = 1'b1;  // Mixed traffic, output never stalls
    run_phase(0, 100);
    drain();
    check_latency = 1'b0;

    // Back-pressure phases, each drains before the next
    hold_ready = 1'b0;
    run_phase(1, 100);
    drain();
    hold_ready = 1'b0;
    run_phase(2, 80);
    drain();
    hold_ready = 1'b0;
    run_phase(3, 120);
    drain();

    if (err_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== fpslice_noncomp_multifmt.f ====
rtl/fpslice_pkg.sv
rtl/fpslice_pipe.sv
rtl/fpslice_noncomp_lane.sv
rtl/fpslice_result_pack.sv
rtl/fpslice_noncomp_multifmt.sv
tests/tb_fpslice_noncomp_multifmt.sv
